// File: tb.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/exec_if.sv
rtl/alu_core.sv
rtl/addr_unit.sv
rtl/exec_commit.sv
rtl/exec_stage.sv
dv/exec_checker.sv
dv/exec_tb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log \
	&& verilator --binary -j 0 --top-module exec_tb -f tb.f \
	&& ./obj_dir/Vexec_tb > sim.log 2>&1 \
	|| echo "build or simulation returned an error"
grep -q "=== PASS ===" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

// File: dv/exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_tb;
	import cpu_pkg::*;

	localparam int NUM_INSTR      = 400;
	localparam int NUM_OPS        = 42;
	localparam int TIMEOUT_CYCLES = 2 * (NUM_INSTR + 20);

	logic        clk = 1'b0;
	logic        rst;
	logic        flush;
	logic        valid;
	oper_t       op;
	logic [31:0] reg1;
	logic [31:0] reg2;
	logic [31:0] instr;
	logic [31:0] pc;
	logic        fetch_err;

	logic        res_valid;
	logic        res_we;
	logic [31:0] res_data;
	logic        mem_read;
	logic        mem_write;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [3:0]  mem_be;
	logic        br_valid;
	logic        br_taken;
	logic [31:0] br_target;
	logic        ex_valid;
	logic [4:0]  ex_code;
	logic [31:0] ex_badvaddr;

	logic [15:0] lfsr;
	oper_t       op_table [0:NUM_OPS-1];
	int          cycles = 0;
	int          check_count;
	int          mismatch_count;
	int          failure_count;

	exec_stage UUT (
		.clk(clk), .rst(rst), .flush(flush), .valid(valid), .op(op),
		.reg1(reg1), .reg2(reg2), .instr(instr), .pc(pc), .fetch_err(fetch_err),
		.res_valid(res_valid), .res_we(res_we), .res_data(res_data),
		.mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_be(mem_be), .br_valid(br_valid),
		.br_taken(br_taken), .br_target(br_target), .ex_valid(ex_valid),
		.ex_code(ex_code), .ex_badvaddr(ex_badvaddr)
	);

	exec_checker u_check (
		.clk(clk), .rst(rst), .flush(flush), .valid(valid), .op(op),
		.reg1(reg1), .reg2(reg2), .instr(instr), .pc(pc), .fetch_err(fetch_err),
		.res_valid(res_valid), .res_we(res_we), .res_data(res_data),
		.mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_be(mem_be), .br_valid(br_valid),
		.br_taken(br_taken), .br_target(br_target), .ex_valid(ex_valid),
		.ex_code(ex_code), .ex_badvaddr(ex_badvaddr),
		.check_count(check_count), .mismatch_count(mismatch_count),
		.failure_count(failure_count)
	);

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val  = {val[30:0], lfsr[0]};
		end
		return val;
	endfunction

	task automatic issue_random();
		logic [31:0] draw;
		logic [31:0] word;
		logic [5:0]  idx;
		draw = take_bits(6);
		idx  = 6'(draw % 32'(NUM_OPS));
		op   = op_table[idx];
		if (take_bits(4) == 32'd0)
			op = OP_INVALID;
		reg1 = take_bits(32);
		reg2 = take_bits(32);
		// equal operands for beq, bne, teq, tne
		if (take_bits(3) == 32'd0)
			reg2 = reg1;
		word = take_bits(32);
		pc   = take_bits(30) << 2;
		if (op == OP_CLZ || op == OP_CLO) begin
			draw = take_bits(5);
			reg1 = reg1 >> draw[4:0];
			if (op == OP_CLO)
				reg1 = ~reg1;
		end
		if ((op == OP_BLEZ || op == OP_BGTZ) && take_bits(2) == 32'd0)
			reg1 = '0;
		// pick the address lane directly
		if (op inside {OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU, OP_SW, OP_SH, OP_SB}) begin
			draw       = take_bits(2);
			reg1[1:0]  = draw[1:0];
			word[1:0]  = 2'b00;
		end
		instr     = word;
		valid     = 1'b1;
		fetch_err = (take_bits(4) == 32'd0);
		flush     = (take_bits(4) == 32'd0);
	endtask

	task automatic drive_idle();
		valid     = 1'b0;
		flush     = 1'b0;
		fetch_err = 1'b0;
		op        = OP_SLL;
		reg1      = '0;
		reg2      = '0;
		instr     = '0;
		pc        = '0;
	endtask

	initial begin
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		lfsr     = 16'd40600;
		op_table = '{OP_LUI, OP_AND, OP_OR, OP_XOR, OP_NOR, OP_ADD, OP_ADDU,
			OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA, OP_SLLV,
			OP_SRLV, OP_SRAV, OP_CLZ, OP_CLO, OP_JAL, OP_JALR, OP_J, OP_BEQ,
			OP_BNE, OP_BLEZ, OP_BGTZ, OP_BLTZ, OP_BGEZ, OP_LW, OP_LH, OP_LHU,
			OP_LB, OP_LBU, OP_SW, OP_SH, OP_SB, OP_TEQ, OP_TNE, OP_TLT, OP_TGE,
			OP_BREAK, OP_SYSCALL};
		rst = 1'b1;
		drive_idle();
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int n = 0; n < NUM_INSTR; n++) begin
			issue_random();
			@(negedge clk);
		end
		drive_idle();
		// one cycle of latency drains the last slot
		repeat (3) @(negedge clk);
		@(posedge clk);
		$display("checks %0d, mismatches %0d, other errors %0d",
			check_count, mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0 && check_count > 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/exec_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module exec_checker (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 flush,
	input  wire                 valid,
	input  wire cpu_pkg::oper_t op,
	input  wire [31:0]          reg1,
	input  wire [31:0]          reg2,
	input  wire [31:0]          instr,
	input  wire [31:0]          pc,
	input  wire                 fetch_err,
	input  wire                 res_valid,
	input  wire                 res_we,
	input  wire [31:0]          res_data,
	input  wire                 mem_read,
	input  wire                 mem_write,
	input  wire [31:0]          mem_addr,
	input  wire [31:0]          mem_wdata,
	input  wire [3:0]           mem_be,
	input  wire                 br_valid,
	input  wire                 br_taken,
	input  wire [31:0]          br_target,
	input  wire                 ex_valid,
	input  wire [4:0]           ex_code,
	input  wire [31:0]          ex_badvaddr,
	output int                  check_count,
	output int                  mismatch_count,
	output int                  failure_count
);
	import cpu_pkg::*;

	typedef struct packed {
		logic        res_valid;
		logic        res_we;
		logic [31:0] res_data;
		logic        mem_read;
		logic        mem_write;
		logic [31:0] mem_addr;
		logic [31:0] mem_wdata;
		logic [3:0]  mem_be;
		logic        br_valid;
		logic        br_taken;
		logic [31:0] br_target;
		logic        ex_valid;
		logic [4:0]  ex_code;
		logic [31:0] ex_badvaddr;
	} expect_t;

	expect_t pending [$];
	int      checks = 0;
	int      mismatches = 0;
	int      failures = 0;

	assign check_count    = checks;
	assign mismatch_count = mismatches;
	assign failure_count  = failures;

	function automatic logic [31:0] leading_count(input logic [31:0] v, input logic bit_val);
		logic [31:0] n;
		logic        run;
		n   = '0;
		run = 1'b1;
		for (int i = 31; i >= 0; i--) begin
			if (run && v[i] == bit_val)
				n = n + 32'd1;
			else
				run = 1'b0;
		end
		return n;
	endfunction

	function automatic expect_t predict(input logic rst_s, input logic flush_s,
		input logic valid_s, input oper_t o, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] word, input logic [31:0] pc_s,
		input logic ferr);
		expect_t     e;
		logic [31:0] imm_ext;
		logic [31:0] vaddr;
		logic [1:0]  lane;
		logic [32:0] wide;
		logic [4:0]  sa;
		logic [31:0] pc4;
		logic [31:0] wd;
		logic [3:0]  be;
		logic        writes;
		logic        ov;
		logic        trap;
		logic        lt_s;
		logic        misaligned;
		logic        is_load;
		logic        is_store;
		logic        is_exc;
		e = '0;
		// empty slot
		if (rst_s || flush_s || !valid_s)
			return e;
		imm_ext = {{16{word[15]}}, word[15:0]};
		sa      = word[10:6];
		lt_s    = $signed(a) < $signed(b);
		pc4     = pc_s + 32'd4;
		writes  = 1'b1;
		ov      = 1'b0;
		wide    = '0;
		case (o)
			OP_LUI:  e.res_data = {word[15:0], 16'h0000};
			OP_AND:  e.res_data = a & b;
			OP_OR:   e.res_data = a | b;
			OP_XOR:  e.res_data = a ^ b;
			OP_NOR:  e.res_data = ~(a | b);
			OP_ADD, OP_ADDU: begin
				wide       = {a[31], a} + {b[31], b};
				e.res_data = wide[31:0];
				ov         = (o == OP_ADD) && (wide[32] != wide[31]);
			end
			OP_SUB, OP_SUBU: begin
				wide       = {a[31], a} - {b[31], b};
				e.res_data = wide[31:0];
				ov         = (o == OP_SUB) && (wide[32] != wide[31]);
			end
			OP_SLT:  e.res_data = {31'b0, lt_s};
			OP_SLTU: e.res_data = {31'b0, a < b};
			OP_SLL:  e.res_data = b << sa;
			OP_SRL:  e.res_data = b >> sa;
			OP_SRA:  e.res_data = $signed(b) >>> sa;
			OP_SLLV: e.res_data = b << a[4:0];
			OP_SRLV: e.res_data = b >> a[4:0];
			OP_SRAV: e.res_data = $signed(b) >>> a[4:0];
			OP_CLZ:  e.res_data = leading_count(a, 1'b0);
			OP_CLO:  e.res_data = leading_count(a, 1'b1);
			OP_JAL, OP_JALR: e.res_data = pc_s + 32'd8;
			default: writes = 1'b0;
		endcase
		case (o)
			OP_TEQ:  trap = (a == b);
			OP_TNE:  trap = (a != b);
			OP_TLT:  trap = lt_s;
			OP_TGE:  trap = !lt_s;
			default: trap = 1'b0;
		endcase

		is_load    = o inside {OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU};
		is_store   = o inside {OP_SW, OP_SH, OP_SB};
		vaddr      = (is_load || is_store) ? a + imm_ext : 32'h0;
		lane       = vaddr[1:0];
		be         = 4'b0000;
		wd         = '0;
		misaligned = 1'b0;
		if (o == OP_LW || o == OP_SW) begin
			be         = 4'b1111;
			wd         = b;
			misaligned = (lane != 2'b00);
		end else if (o inside {OP_LH, OP_LHU, OP_SH}) begin
			be         = lane[1] ? 4'b1100 : 4'b0011;
			wd         = lane[1] ? {b[15:0], 16'h0000} : {16'h0000, b[15:0]};
			misaligned = lane[0];
		end else if (o inside {OP_LB, OP_LBU, OP_SB}) begin
			case (lane)
				2'd0: begin
					be = 4'b0001;
					wd = {24'h0, b[7:0]};
				end
				2'd1: begin
					be = 4'b0010;
					wd = {16'h0, b[7:0], 8'h0};
				end
				2'd2: begin
					be = 4'b0100;
					wd = {8'h0, b[7:0], 16'h0};
				end
				default: begin
					be = 4'b1000;
					wd = {b[7:0], 24'h0};
				end
			endcase
		end

		e.br_target = pc4 + (imm_ext << 2);
		case (o)
			OP_BEQ:  e.br_taken = (a == b);
			OP_BNE:  e.br_taken = (a != b);
			OP_BLEZ: e.br_taken = ($signed(a) <= 0);
			OP_BGTZ: e.br_taken = ($signed(a) > 0);
			OP_BLTZ: e.br_taken = ($signed(a) < 0);
			OP_BGEZ: e.br_taken = ($signed(a) >= 0);
			OP_J, OP_JAL: begin
				e.br_taken  = 1'b1;
				e.br_target = {pc4[31:28], word[25:0], 2'b00};
			end
			OP_JALR: begin
				e.br_taken  = 1'b1;
				e.br_target = a;
			end
			default: e.br_taken = 1'b0;
		endcase
		e.br_valid = o inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BLTZ, OP_BGEZ,
			OP_J, OP_JAL, OP_JALR};

		is_exc = 1'b1;
		if (ferr) begin
			e.ex_code     = `EXCCODE_ADEL;
			e.ex_badvaddr = pc_s;
		end else if (o == OP_INVALID) begin
			e.ex_code = `EXCCODE_RI;
		end else if (trap) begin
			e.ex_code = `EXCCODE_TR;
		end else if (o == OP_BREAK) begin
			e.ex_code = `EXCCODE_BP;
		end else if (o == OP_SYSCALL) begin
			e.ex_code = `EXCCODE_SYS;
		end else if (ov) begin
			e.ex_code = `EXCCODE_OV;
		end else if ((is_load || is_store) && misaligned) begin
			e.ex_code     = is_store ? `EXCCODE_ADES : `EXCCODE_ADEL;
			e.ex_badvaddr = vaddr;
		end else begin
			is_exc = 1'b0;
		end

		e.res_valid = 1'b1;
		e.ex_valid  = is_exc;
		e.res_we    = writes && !is_exc;
		e.mem_read  = is_load && !is_exc;
		e.mem_write = is_store && !is_exc;
		e.mem_be    = ((is_load || is_store) && !is_exc) ? be : 4'b0000;
		e.mem_addr  = vaddr;
		e.mem_wdata = wd;
		return e;
	endfunction

	task automatic check_field(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH %s expected %08h actual %08h at %0t", name, exp, act, $time);
		end
	endtask

	// inputs change on the falling edge and are stable here
	always @(posedge clk) begin
		pending.push_back(predict(rst, flush, valid, op, reg1, reg2, instr, pc, fetch_err));
	end

	always @(negedge clk) begin : compare_slot
		expect_t e;
		if (pending.size() == 0) begin
			failures++;
			$display("no prediction was queued for the output check at %0t", $time);
		end else begin
			e = pending.pop_front();
			check_field("res_valid", 32'(e.res_valid), 32'(res_valid));
			check_field("res_we", 32'(e.res_we), 32'(res_we));
			check_field("mem_read", 32'(e.mem_read), 32'(mem_read));
			check_field("mem_write", 32'(e.mem_write), 32'(mem_write));
			check_field("mem_be", 32'(e.mem_be), 32'(mem_be));
			check_field("br_valid", 32'(e.br_valid), 32'(br_valid));
			check_field("br_taken", 32'(e.br_taken), 32'(br_taken));
			check_field("ex_valid", 32'(e.ex_valid), 32'(ex_valid));
			// payloads only where the slot carries them
			if (e.res_we)
				check_field("res_data", e.res_data, res_data);
			if (e.mem_read || e.mem_write)
				check_field("mem_addr", e.mem_addr, mem_addr);
			if (e.mem_write)
				check_field("mem_wdata", e.mem_wdata, mem_wdata);
			if (e.br_valid)
				check_field("br_target", e.br_target, br_target);
			if (e.ex_valid) begin
				check_field("ex_code", 32'(e.ex_code), 32'(ex_code));
				check_field("ex_badvaddr", e.ex_badvaddr, ex_badvaddr);
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  flush,
	input  wire                  valid,
	input  wire cpu_pkg::oper_t  op,
	input  wire [31:0]           reg1,
	input  wire [31:0]           reg2,
	input  wire cpu_pkg::instr_t instr,
	input  wire [31:0]           pc,
	input  wire                  fetch_err,
	output logic                 res_valid,
	output logic                 res_we,
	output logic [31:0]          res_data,
	output logic                 mem_read,
	output logic                 mem_write,
	output logic [31:0]          mem_addr,
	output logic [31:0]          mem_wdata,
	output logic [3:0]           mem_be,
	output logic                 br_valid,
	output logic                 br_taken,
	output logic [31:0]          br_target,
	output logic                 ex_valid,
	output logic [4:0]           ex_code,
	output logic [31:0]          ex_badvaddr
);
	import cpu_pkg::*;

	alu_out_t  alu_res;
	addr_out_t addr_res;

	exec_operands_if ops_if ();

	// issued instruction onto the shared bundle
	assign ops_if.valid     = valid;
	assign ops_if.op        = op;
	assign ops_if.reg1      = reg1;
	assign ops_if.reg2      = reg2;
	assign ops_if.instr     = instr;
	assign ops_if.pc        = pc;
	assign ops_if.fetch_err = fetch_err;

	alu_core u_alu (
		.ops     (ops_if),
		.alu_res (alu_res)
	);

	addr_unit u_agu (
		.ops      (ops_if),
		.addr_res (addr_res)
	);

	exec_commit u_commit (
		.clk         (clk),
		.rst         (rst),
		.flush       (flush),
		.ops         (ops_if),
		.alu_res     (alu_res),
		.addr_res    (addr_res),
		.res_valid   (res_valid),
		.res_we      (res_we),
		.res_data    (res_data),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_be      (mem_be),
		.br_valid    (br_valid),
		.br_taken    (br_taken),
		.br_target   (br_target),
		.ex_valid    (ex_valid),
		.ex_code     (ex_code),
		.ex_badvaddr (ex_badvaddr)
	);

endmodule

`default_nettype wire

// File: rtl/exec_commit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module exec_commit (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    flush,
	exec_operands_if.commit        ops,
	input  wire cpu_pkg::alu_out_t  alu_res,
	input  wire cpu_pkg::addr_out_t addr_res,
	output logic                   res_valid,
	output logic                   res_we,
	output logic [31:0]            res_data,
	output logic                   mem_read,
	output logic                   mem_write,
	output logic [31:0]            mem_addr,
	output logic [31:0]            mem_wdata,
	output logic [3:0]             mem_be,
	output logic                   br_valid,
	output logic                   br_taken,
	output logic [31:0]            br_target,
	output logic                   ex_valid,
	output logic [4:0]             ex_code,
	output logic [31:0]            ex_badvaddr
);
	import cpu_pkg::*;

	logic        ex_any;
	logic        keep;
	logic [4:0]  code_d;
	logic [31:0] badvaddr_d;

	// fetch error first, unaligned data last
	always_comb begin
		ex_any     = 1'b1;
		code_d     = '0;
		badvaddr_d = '0;
		if (ops.fetch_err) begin
			code_d     = `EXCCODE_ADEL;
			badvaddr_d = ops.pc;
		end else if (ops.op == OP_INVALID) begin
			code_d = `EXCCODE_RI;
		end else if (alu_res.trap) begin
			code_d = `EXCCODE_TR;
		end else if (ops.op == OP_BREAK) begin
			code_d = `EXCCODE_BP;
		end else if (ops.op == OP_SYSCALL) begin
			code_d = `EXCCODE_SYS;
		end else if (alu_res.ov) begin
			code_d = `EXCCODE_OV;
		end else if (addr_res.unaligned) begin
			code_d     = addr_res.mem_write ? `EXCCODE_ADES : `EXCCODE_ADEL;
			badvaddr_d = addr_res.vaddr;
		end else begin
			ex_any = 1'b0;
		end
	end

	// side effects only for clean instructions
	assign keep = ops.valid && !ex_any;

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			res_valid <= 1'b0;
			res_we    <= 1'b0;
			mem_read  <= 1'b0;
			mem_write <= 1'b0;
			mem_be    <= 4'b0000;
			br_valid  <= 1'b0;
			br_taken  <= 1'b0;
			ex_valid  <= 1'b0;
		end else begin
			res_valid <= ops.valid;
			res_we    <= keep && alu_res.we;
			mem_read  <= keep && addr_res.mem_read;
			mem_write <= keep && addr_res.mem_write;
			mem_be    <= keep ? addr_res.be : 4'b0000;
			// branch still reported beside an exception
			br_valid  <= ops.valid && addr_res.br_valid;
			br_taken  <= ops.valid && addr_res.br_taken;
			ex_valid  <= ops.valid && ex_any;
		end
	end

	always_ff @(posedge clk) begin
		res_data    <= alu_res.result;
		mem_addr    <= addr_res.vaddr;
		mem_wdata   <= addr_res.wdata;
		br_target   <= addr_res.br_target;
		ex_code     <= code_d;
		ex_badvaddr <= badvaddr_d;
	end

endmodule

`default_nettype wire

// File: rtl/addr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module addr_unit (
	exec_operands_if.agu        ops,
	output cpu_pkg::addr_out_t  addr_res
);
	import cpu_pkg::*;

	logic [31:0] ext_imm;
	logic [31:0] sum_addr;
	logic [31:0] pc_plus4;
	logic [31:0] target_b;
	logic [31:0] target_j;
	logic [1:0]  lane;
	logic        is_load;
	logic        is_store;
	logic        reg_equal;
	logic        reg1_zero;
	logic [31:0] wdata;
	logic [3:0]  be;
	logic        misaligned;
	logic        br_valid;
	logic        br_taken;
	logic [31:0] br_target;

	assign ext_imm  = {{16{ops.instr.i.imm16[15]}}, ops.instr.i.imm16};
	assign sum_addr = ops.reg1 + ext_imm;
	assign lane     = sum_addr[1:0];

	assign is_load  = ops.op inside {OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU};
	assign is_store = ops.op inside {OP_SW, OP_SH, OP_SB};

	always_comb begin
		be         = 4'b0000;
		wdata      = '0;
		misaligned = 1'b0;
		unique case (ops.op)
			OP_LW, OP_SW: begin
				be         = 4'b1111;
				wdata      = ops.reg2;
				misaligned = |lane;
			end
			OP_LH, OP_LHU, OP_SH: begin
				be         = lane[1] ? 4'b1100 : 4'b0011;
				wdata      = lane[1] ? {ops.reg2[15:0], 16'b0} : {16'b0, ops.reg2[15:0]};
				misaligned = lane[0];
			end
			OP_LB, OP_LBU, OP_SB: begin
				be    = 4'b0001 << lane;
				wdata = {24'b0, ops.reg2[7:0]} << {lane, 3'b000};
			end
			default: ;
		endcase
		// loads carry no store data
		if (!is_store)
			wdata = '0;
	end

	assign pc_plus4  = ops.pc + 32'd4;
	assign target_b  = pc_plus4 + {{14{ops.instr.i.imm16[15]}}, ops.instr.i.imm16, 2'b00};
	assign target_j  = {pc_plus4[31:28], ops.instr.j.index26, 2'b00};
	assign reg_equal = ops.reg1 == ops.reg2;
	assign reg1_zero = ops.reg1 == '0;

	always_comb begin
		br_valid  = 1'b1;
		br_taken  = 1'b1;
		br_target = target_b;
		unique case (ops.op)
			OP_BEQ:         br_taken = reg_equal;
			OP_BNE:         br_taken = !reg_equal;
			OP_BLEZ:        br_taken = reg1_zero || ops.reg1[31];
			OP_BGTZ:        br_taken = !reg1_zero && !ops.reg1[31];
			OP_BLTZ:        br_taken = ops.reg1[31];
			OP_BGEZ:        br_taken = !ops.reg1[31];
			OP_J, OP_JAL:   br_target = target_j;
			OP_JALR:        br_target = ops.reg1;
			default: begin
				br_valid  = 1'b0;
				br_taken  = 1'b0;
				br_target = '0;
			end
		endcase
	end

	assign addr_res = '{
		mem_read:  is_load,
		mem_write: is_store,
		vaddr:     (is_load || is_store) ? sum_addr : '0,
		wdata:     wdata,
		be:        be,
		unaligned: misaligned,
		br_valid:  br_valid,
		br_taken:  br_taken,
		br_target: br_target
	};

endmodule

`default_nettype wire

// File: rtl/alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module alu_core (
	exec_operands_if.alu       ops,
	output cpu_pkg::alu_out_t  alu_res
);
	import cpu_pkg::*;

	logic [31:0] sum;
	logic [31:0] diff;
	logic [31:0] pc_plus8;
	logic [31:0] res_val;
	logic        res_we;
	logic        ov_add;
	logic        ov_sub;
	logic        ov_hit;
	logic        signed_lt;
	logic        unsigned_lt;
	logic        reg_equal;
	logic        trap_hit;
	logic [4:0]  shamt;
	logic [4:0]  shamt_v;
	logic [31:0] lead_src;
	logic [5:0]  lead_cnt;
	logic        lead_hit;

	assign sum      = ops.reg1 + ops.reg2;
	assign diff     = ops.reg1 - ops.reg2;
	assign pc_plus8 = ops.pc + 32'd8;
	assign shamt    = ops.instr.r.shamt;
	assign shamt_v  = ops.reg1[4:0];

	assign ov_add = (ops.reg1[31] == ops.reg2[31]) && (ops.reg1[31] != sum[31]);
	assign ov_sub = (ops.reg1[31] != ops.reg2[31]) && (ops.reg1[31] != diff[31]);
	assign ov_hit = (ops.op == OP_ADD && ov_add) || (ops.op == OP_SUB && ov_sub);

	// shared comparator for slt and traps
	assign signed_lt   = (ops.reg1[31] != ops.reg2[31]) ? ops.reg1[31] : diff[31];
	assign unsigned_lt = ops.reg1 < ops.reg2;
	assign reg_equal   = ops.reg1 == ops.reg2;

	// clo is clz of the inverted operand
	assign lead_src = (ops.op == OP_CLO) ? ~ops.reg1 : ops.reg1;

	always_comb begin
		lead_cnt = 6'd32;
		lead_hit = 1'b0;
		for (int i = 31; i >= 0; i--) begin
			if (!lead_hit && lead_src[i]) begin
				lead_cnt = 6'(31 - i);
				lead_hit = 1'b1;
			end
		end
	end

	always_comb begin
		res_val = '0;
		res_we  = 1'b1;
		unique case (ops.op)
			OP_LUI:           res_val = {ops.instr.i.imm16, 16'b0};
			OP_AND:           res_val = ops.reg1 & ops.reg2;
			OP_OR:            res_val = ops.reg1 | ops.reg2;
			OP_XOR:           res_val = ops.reg1 ^ ops.reg2;
			OP_NOR:           res_val = ~(ops.reg1 | ops.reg2);
			OP_ADD, OP_ADDU:  res_val = sum;
			OP_SUB, OP_SUBU:  res_val = diff;
			OP_SLT:           res_val = {31'b0, signed_lt};
			OP_SLTU:          res_val = {31'b0, unsigned_lt};
			OP_SLL:           res_val = ops.reg2 << shamt;
			OP_SRL:           res_val = ops.reg2 >> shamt;
			OP_SRA:           res_val = $signed(ops.reg2) >>> shamt;
			OP_SLLV:          res_val = ops.reg2 << shamt_v;
			OP_SRLV:          res_val = ops.reg2 >> shamt_v;
			OP_SRAV:          res_val = $signed(ops.reg2) >>> shamt_v;
			OP_CLZ, OP_CLO:   res_val = {26'b0, lead_cnt};
			// link address skips the delay slot
			OP_JAL, OP_JALR:  res_val = pc_plus8;
			default:          res_we = 1'b0;
		endcase
	end

	always_comb begin
		unique case (ops.op)
			OP_TEQ:  trap_hit = reg_equal;
			OP_TNE:  trap_hit = !reg_equal;
			OP_TLT:  trap_hit = signed_lt;
			OP_TGE:  trap_hit = !signed_lt;
			default: trap_hit = 1'b0;
		endcase
	end

	assign alu_res = '{result: res_val, we: res_we, ov: ov_hit, trap: trap_hit};

endmodule

`default_nettype wire

// File: rtl/exec_if.sv
`timescale 1ns/1ps
`default_nettype none

interface exec_operands_if;
	import cpu_pkg::*;

	logic        valid;
	oper_t       op;
	logic [31:0] reg1;
	logic [31:0] reg2;
	instr_t      instr;
	logic [31:0] pc;
	logic        fetch_err;

	modport src (output valid, op, reg1, reg2, instr, pc, fetch_err);

	// both execution units see operands only
	modport alu (input op, reg1, reg2, instr, pc);
	modport agu (input op, reg1, reg2, instr, pc);

	modport commit (input valid, op, pc, fetch_err);

endinterface

`default_nettype wire

// File: rtl/cpu_pkg.sv
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

	typedef enum logic [`OP_WIDTH-1:0] {
		// logic and arithmetic
		OP_LUI, OP_AND, OP_OR, OP_XOR, OP_NOR,
		OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
		// shifts
		OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
		// leading bit counts
		OP_CLZ, OP_CLO,
		// control flow
		OP_JAL, OP_JALR, OP_J,
		OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BLTZ, OP_BGEZ,
		// memory
		OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU,
		OP_SW, OP_SH, OP_SB,
		// traps and system
		OP_TEQ, OP_TNE, OP_TLT, OP_TGE, OP_BREAK, OP_SYSCALL,
		OP_INVALID
	} oper_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instr_r_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} instr_i_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] index26;
	} instr_j_t;

	// three field layouts over one instruction word
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
		instr_j_t j;
	} instr_t;

	typedef struct packed {
		logic [31:0] result;
		logic        we;
		logic        ov;
		logic        trap;
	} alu_out_t;

	typedef struct packed {
		logic        mem_read;
		logic        mem_write;
		logic [31:0] vaddr;
		logic [31:0] wdata;
		logic [3:0]  be;
		logic        unaligned;
		logic        br_valid;
		logic        br_taken;
		logic [31:0] br_target;
	} addr_out_t;

endpackage

`default_nettype wire

// File: rtl/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// exception codes as seen in the cause register
`define EXCCODE_ADEL 5'd4
`define EXCCODE_ADES 5'd5
`define EXCCODE_SYS  5'd8
`define EXCCODE_BP   5'd9
`define EXCCODE_RI   5'd10
`define EXCCODE_OV   5'd12
`define EXCCODE_TR   5'd13

// decoded operation code width
`define OP_WIDTH 6

`endif
